// ==== elevator.f ====
hdl/elevator_pkg.sv
hdl/call_register.sv
hdl/travel_planner.sv
hdl/door_sequencer.sv
hdl/car_controller.sv
hdl/elevator.sv
tests/elevator_sva.sv
tests/elevator_tb.sv

// ==== Makefile ====
# Verilator build and run for the elevator testbench

LOG = sim.log

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module elevator_tb \
		-f elevator.f -o Velevator_tb

run: compile
	./obj_dir/Velevator_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Simulation finished: FAIL" $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: compile run clean

// ==== tests/elevator_tb.sv ====
// elevator testbench with shaft and door model and table-driven call scenarios
`timescale 1ns/1ps

module elevator_tb
	import elevator_pkg::*;
();

	localparam int num_rows = 6;

	logic clk = 1'b0;
	logic reset = 1'b0;
	logic open_btn = 1'b0;
	logic close_btn = 1'b0;
	logic overload = 1'b0;
	logic sensor_inside = 1'b0;
	logic sensor_door = 1'b1; // starts closed
	logic aligned = 1'b1; // drives both floor sensors
	floor_vec_t btn_in = '0;
	floor_vec_t btn_up_out = '0;
	floor_vec_t btn_down_out = '0;
	engine_t engine;
	door_t door;
	floor_t level_display;

	int shaft_cnt = 0;
	int door_cnt = 0;
	int parked = 0; // floor of the last stop
	int level_q[$]; // floors shown since the last stop
	floor_t last_level = '0;
	logic [31:0] rng;

	string row_name [num_rows];
	int row_kind [num_rows]; // 0 cab, 1 hall up, 2 hall down, 3 none
	int row_floor [num_rows];
	int row_kind2 [num_rows];
	int row_floor2 [num_rows];
	int row_safety [num_rows]; // 0 none, 1 light curtain, 2 overload
	int row_nstops [num_rows];
	int row_stops [num_rows][2];

	elevator i_elevator (
		.clk(clk),
		.reset(reset),
		.open_btn(open_btn),
		.close_btn(close_btn),
		.overload(overload),
		.sensor_up(aligned),
		.sensor_down(aligned),
		.sensor_inside(sensor_inside),
		.sensor_door(sensor_door),
		.btn_in(btn_in),
		.btn_up_out(btn_up_out),
		.btn_down_out(btn_down_out),
		.engine(engine),
		.door(door),
		.level_display(level_display)
	);

	bind elevator elevator_sva i_elevator_sva (
		.clk(clk),
		.reset(reset),
		.engine(engine),
		.door(door),
		.level_display(level_display)
	);

	always #50 clk = ~clk;

	// alignment drops 3 cycles into a run and returns 5 cycles later
	always @(posedge clk) begin
		#1;
		if (engine == engine_idle) begin
			shaft_cnt = 0;
			aligned = 1'b1;
		end else begin
			shaft_cnt = shaft_cnt + 1;
			if (shaft_cnt == 3) begin
				aligned = 1'b0;
			end else if (shaft_cnt == 8) begin
				aligned = 1'b1; // next floor reached
				shaft_cnt = 0;
			end
		end
	end

	// door sensor follows the command after 2 cycles
	always @(posedge clk) begin
		#1;
		if ((door == door_open && sensor_door) || (door == door_close && !sensor_door)) begin
			door_cnt = door_cnt + 1;
			if (door_cnt == 2) begin
				sensor_door = ~sensor_door;
				door_cnt = 0;
			end
		end else begin
			door_cnt = 0;
		end
	end

	always @(negedge clk) begin
		if (reset && level_display != last_level) begin
			level_q.push_back(int'(level_display));
			last_level = level_display;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "wait timed out");
	endtask

	task automatic set_row(input int r, input string name, input int k1, input int f1,
			input int k2, input int f2, input int safety, input int n, input int s0, input int s1);
		row_name[r] = name;
		row_kind[r] = k1;
		row_floor[r] = f1;
		row_kind2[r] = k2;
		row_floor2[r] = f2;
		row_safety[r] = safety;
		row_nstops[r] = n;
		row_stops[r][0] = s0;
		row_stops[r][1] = s1;
	endtask

	task automatic press(input int kind, input int floor);
		case (kind)
			0: btn_in[floor] = 1'b1;
			1: btn_up_out[floor] = 1'b1;
			2: btn_down_out[floor] = 1'b1;
			default: ;
		endcase
	endtask

	// the car has to stay parked while the door cycles
	task automatic wait_door(input door_t target, input string what);
		int n;
		n = 0;
		while (door != target) begin
			if (n == 200) fail_timeout(what);
			@(negedge clk);
			n++;
			check_value({what, " engine"}, int'(engine_idle), int'(engine));
		end
	endtask

	task automatic wait_stop(input int stop, input string name);
		int n;
		int limit;
		int step;
		int f;
		n = 0;
		limit = (stop == parked) ? 3 : 200; // own floor opens within 3 cycles
		while (door != door_open) begin
			if (n == limit) fail_timeout({name, " door opening"});
			@(negedge clk);
			n++;
			if (stop == parked) begin
				check_value({name, " engine at own floor"}, int'(engine_idle), int'(engine));
			end
		end
		step = (stop > parked) ? 1 : -1;
		check_value({name, " floors passed"}, (stop - parked) * step, level_q.size());
		f = parked;
		while (f != stop) begin
			f = f + step;
			check_value({name, " floor step"}, f, level_q.pop_front());
		end
		check_value({name, " stop floor"}, stop, int'(level_display));
		parked = stop;
	endtask

	task automatic door_cycle(input int safety, input string name);
		if (safety == 2) begin
			@(posedge clk);
			#1;
			overload = 1'b1;
			repeat (20) begin
				@(negedge clk);
				check_value({name, " door held open"}, 0, int'(door == door_close));
				check_value({name, " engine held"}, int'(engine_idle), int'(engine));
			end
			@(posedge clk);
			#1;
			overload = 1'b0;
		end
		wait_door(door_close, {name, " door close"});
		if (safety == 1) begin
			@(posedge clk);
			#1;
			sensor_inside = 1'b1; // someone steps into the doorway
			wait_door(door_open, {name, " reopen after light curtain"});
			@(posedge clk);
			#1;
			sensor_inside = 1'b0;
			wait_door(door_close, {name, " second door close"});
		end
		wait_door(door_idle, {name, " door closed"});
	endtask

	initial begin
		int gap;
		rng = 32'h1814;
		set_row(0, "idle_after_reset", 3, 0, 3, 0, 0, 0, 0, 0);
		set_row(1, "cab_to_5", 0, 5, 3, 0, 0, 1, 5, 0);
		set_row(2, "collective_order", 0, 1, 1, 3, 0, 2, 1, 3);
		set_row(3, "light_curtain", 0, 6, 0, 7, 1, 2, 6, 7);
		set_row(4, "overload_hold", 0, 2, 0, 0, 2, 2, 2, 0);
		set_row(5, "hall_own_floor", 1, 0, 3, 0, 0, 1, 0, 0);
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b1;
		for (int r = 0; r < num_rows; r++) begin
			rng = xorshift(rng);
			gap = 1 + int'(rng[1:0]);
			repeat (gap) @(posedge clk);
			#1;
			press(row_kind[r], row_floor[r]);
			press(row_kind2[r], row_floor2[r]);
			@(posedge clk);
			#1;
			btn_in = '0;
			btn_up_out = '0;
			btn_down_out = '0;
			if (row_nstops[r] == 0) begin
				repeat (20) begin
					@(negedge clk);
					check_value({row_name[r], " engine"}, int'(engine_idle), int'(engine));
					check_value({row_name[r], " door"}, int'(door_idle), int'(door));
					check_value({row_name[r], " level"}, parked, int'(level_display));
				end
			end
			for (int s = 0; s < row_nstops[r]; s++) begin
				wait_stop(row_stops[r][s], row_name[r]);
				door_cycle((s == 0) ? row_safety[r] : 0, row_name[r]);
			end
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== tests/elevator_sva.sv ====
// elevator assertions: engine and door interlock, legal encodings, single floor steps
`timescale 1ns/1ps

module elevator_sva
	import elevator_pkg::*;
(
	input logic clk,
	input logic reset,
	input engine_t engine,
	input door_t door,
	input floor_t level_display
);

	// the car only moves with the door parked closed
	property engine_door_interlock;
		@(posedge clk) disable iff (!reset)
			(engine != engine_idle) |-> (door == door_idle);
	endproperty

	property legal_codes;
		@(posedge clk) disable iff (!reset)
			(engine != 2'd3) && (door != 2'd3);
	endproperty

	property level_single_step;
		@(posedge clk) disable iff (!reset)
			(level_display == $past(level_display))
			|| (level_display == floor_t'($past(level_display) + 1'b1))
			|| (level_display == floor_t'($past(level_display) - 1'b1));
	endproperty

	a_interlock: assert property (engine_door_interlock)
		else $error("engine running while a door command is active");
	a_codes: assert property (legal_codes)
		else $error("engine or door command has the unused encoding 3");
	a_step: assert property (level_single_step)
		else $error("level display jumped by more than one floor");

endmodule

// ==== hdl/elevator.sv ====
// elevator top: call registers, planner, door sequencer and car controller
`timescale 1ns/1ps

module elevator
	import elevator_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic open_btn,
	input logic close_btn,
	input logic overload,
	input logic sensor_up,
	input logic sensor_down,
	input logic sensor_inside,
	input logic sensor_door,
	input floor_vec_t btn_in,
	input floor_vec_t btn_up_out,
	input floor_vec_t btn_down_out,
	output engine_t engine,
	output door_t door,
	output floor_t level_display
);

	floor_vec_t cab_calls;
	floor_vec_t up_calls;
	floor_vec_t down_calls;
	floor_vec_t serve_cab;
	floor_vec_t serve_up;
	floor_vec_t serve_down;
	floor_t current_floor;
	logic going_up;
	logic stop_here;
	logic calls_ahead;
	logic calls_behind;
	logic depart_up;
	logic open_req;
	logic door_done;

	assign level_display = current_floor;

	call_register #(
		.valid_mask('1)
	) i_cab_calls (
		.clk(clk),
		.reset(reset),
		.press(btn_in),
		.serve(serve_cab),
		.calls(cab_calls)
	);

	// no up call from the top floor
	call_register #(
		.valid_mask({1'b0, {(num_floors-1){1'b1}}})
	) i_up_calls (
		.clk(clk),
		.reset(reset),
		.press(btn_up_out),
		.serve(serve_up),
		.calls(up_calls)
	);

	// no down call from floor 0
	call_register #(
		.valid_mask({{(num_floors-1){1'b1}}, 1'b0})
	) i_down_calls (
		.clk(clk),
		.reset(reset),
		.press(btn_down_out),
		.serve(serve_down),
		.calls(down_calls)
	);

	travel_planner i_travel_planner (
		.cab_calls(cab_calls),
		.up_calls(up_calls),
		.down_calls(down_calls),
		.current_floor(current_floor),
		.going_up(going_up),
		.stop_here(stop_here),
		.calls_ahead(calls_ahead),
		.calls_behind(calls_behind),
		.depart_up(depart_up)
	);

	door_sequencer i_door_sequencer (
		.clk(clk),
		.reset(reset),
		.open_req(open_req),
		.open_btn(open_btn),
		.close_btn(close_btn),
		.overload(overload),
		.sensor_inside(sensor_inside),
		.sensor_door(sensor_door),
		.door(door),
		.door_done(door_done)
	);

	car_controller i_car_controller (
		.clk(clk),
		.reset(reset),
		.sensor_up(sensor_up),
		.sensor_down(sensor_down),
		.stop_here(stop_here),
		.calls_ahead(calls_ahead),
		.calls_behind(calls_behind),
		.depart_up(depart_up),
		.door_done(door_done),
		.going_up(going_up),
		.current_floor(current_floor),
		.engine(engine),
		.open_req(open_req),
		.serve_cab(serve_cab),
		.serve_up(serve_up),
		.serve_down(serve_down)
	);

endmodule

// ==== hdl/car_controller.sv ====
// car controller: car FSM, floor tracking, engine command and call service
`timescale 1ns/1ps

module car_controller
	import elevator_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic sensor_up,
	input logic sensor_down,
	input logic stop_here,
	input logic calls_ahead,
	input logic calls_behind,
	input logic depart_up,
	input logic door_done,
	output logic going_up,
	output floor_t current_floor,
	output engine_t engine,
	output logic open_req,
	output floor_vec_t serve_cab,
	output floor_vec_t serve_up,
	output floor_vec_t serve_down
);

	typedef enum logic [1:0] {
		st_idle,
		st_doors,
		st_leaving,
		st_travelling
	} car_state_t;

	car_state_t state;
	floor_t floor_q;
	logic aligned;
	logic aligned_q;
	logic arrive;
	logic serve_now;
	floor_vec_t here;

	assign aligned = sensor_up & sensor_down;
	assign arrive = (state == st_travelling) && aligned && !aligned_q; // alignment returns

	// the new floor shows up in the arrival cycle so the planner sees it at once
	always_comb begin
		current_floor = floor_q;
		if (arrive) begin
			if (engine == engine_up) begin
				current_floor = floor_q + 1'b1;
			end else begin
				current_floor = floor_q - 1'b1;
			end
		end
	end

	assign serve_now = stop_here && ((state == st_idle) || arrive);
	assign here = floor_vec_t'(1) << current_floor;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= st_idle;
			floor_q <= '0;
			going_up <= 1'b1;
			aligned_q <= 1'b0;
			engine <= engine_idle;
			open_req <= 1'b0;
			serve_cab <= '0;
			serve_up <= '0;
			serve_down <= '0;
		end else begin
			aligned_q <= aligned;
			floor_q <= current_floor;
			open_req <= 1'b0; // strobes default low
			serve_cab <= '0;
			serve_up <= '0;
			serve_down <= '0;
			if (serve_now) begin
				engine <= engine_idle;
				open_req <= 1'b1;
				state <= st_doors;
				serve_cab <= here;
				if (calls_ahead) begin
					if (going_up) begin
						serve_up <= here;
					end else begin
						serve_down <= here;
					end
				end else begin
					// end of the run: take this floor's hall calls and turn
					serve_up <= here;
					serve_down <= here;
					going_up <= ~going_up;
				end
			end else begin
				case (state)
					st_idle: begin
						if (calls_ahead || calls_behind) begin
							going_up <= depart_up;
							engine <= depart_up ? engine_up : engine_down;
							state <= st_leaving;
						end
					end
					st_doors: begin
						if (door_done) begin
							state <= st_idle;
						end
					end
					st_leaving: begin
						if (!aligned) begin
							state <= st_travelling; // left the floor zone
						end
					end
					st_travelling: begin
						if (arrive) begin
							state <= st_leaving; // pass through, engine stays on
						end
					end
					default: state <= st_idle;
				endcase
			end
		end
	end

endmodule

// ==== hdl/door_sequencer.sv ====
// door sequencer: open, dwell and close cycle with light curtain and overload
`timescale 1ns/1ps

module door_sequencer
	import elevator_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic open_req,
	input logic open_btn,
	input logic close_btn,
	input logic overload,
	input logic sensor_inside,
	input logic sensor_door, // 0 opened, 1 closed
	output door_t door,
	output logic door_done
);

	typedef enum logic [1:0] {
		ph_closed,
		ph_opening,
		ph_dwell,
		ph_closing
	} door_phase_t;

	door_phase_t phase;
	logic [dwell_w-1:0] dwell_cnt;
	logic dwell_end;

	assign dwell_end = (dwell_cnt == dwell_w'(dwell_cycles - 1)) || close_btn;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			phase <= ph_closed;
			dwell_cnt <= '0;
			door_done <= 1'b0;
		end else begin
			door_done <= 1'b0;
			case (phase)
				ph_closed: begin
					if (open_req) begin
						phase <= ph_opening;
					end
				end
				ph_opening: begin
					if (!sensor_door) begin // fully opened
						phase <= ph_dwell;
						dwell_cnt <= '0;
					end
				end
				ph_dwell: begin
					if (overload) begin
						dwell_cnt <= '0; // hold until the load drops
					end else if (dwell_end) begin
						phase <= ph_closing;
					end else begin
						dwell_cnt <= dwell_cnt + 1'b1;
					end
				end
				ph_closing: begin
					if (open_btn || sensor_inside) begin
						phase <= ph_opening; // reopen, full dwell again
					end else if (sensor_door) begin
						phase <= ph_closed;
						door_done <= 1'b1;
					end
				end
				default: phase <= ph_closed;
			endcase
		end
	end

	always_comb begin
		case (phase)
			ph_opening: door = door_open;
			ph_closing: door = door_close;
			default: door = door_idle;
		endcase
	end

endmodule

// ==== hdl/travel_planner.sv ====
// travel planner: selective-collective stop and direction decision
`timescale 1ns/1ps

module travel_planner
	import elevator_pkg::*;
(
	input floor_vec_t cab_calls,
	input floor_vec_t up_calls,
	input floor_vec_t down_calls,
	input floor_t current_floor,
	input logic going_up,
	output logic stop_here,
	output logic calls_ahead,
	output logic calls_behind,
	output logic depart_up
);

	floor_vec_t above_mask;
	floor_vec_t below_mask;
	floor_vec_t all_calls;
	logic any_above;
	logic any_below;
	logic cab_here;
	logic hall_with; // hall call at this floor in travel direction
	logic hall_against;

	// floors strictly above and below the car
	always_comb begin
		for (int i = 0; i < num_floors; i++) begin
			above_mask[i] = (i > current_floor);
			below_mask[i] = (i < current_floor);
		end
	end

	assign all_calls = cab_calls | up_calls | down_calls;
	assign any_above = |(all_calls & above_mask);
	assign any_below = |(all_calls & below_mask);

	assign calls_ahead = going_up ? any_above : any_below;
	assign calls_behind = going_up ? any_below : any_above;

	assign cab_here = cab_calls[current_floor];
	assign hall_with = going_up ? up_calls[current_floor] : down_calls[current_floor];
	assign hall_against = going_up ? down_calls[current_floor] : up_calls[current_floor];

	// an opposite hall call is only taken at the end of the run
	assign stop_here = cab_here | hall_with | (hall_against & ~calls_ahead);

	// keep going while work is ahead, else turn round if work is behind
	always_comb begin
		if (calls_ahead) begin
			depart_up = going_up;
		end else if (calls_behind) begin
			depart_up = ~going_up;
		end else begin
			depart_up = going_up;
		end
	end

endmodule

// ==== hdl/call_register.sv ====
// call register: latches one kind of floor call until the car serves it
`timescale 1ns/1ps

module call_register
	import elevator_pkg::*;
#(
	parameter floor_vec_t valid_mask = '1 // floors where this call can exist
)
(
	input logic clk,
	input logic reset,
	input floor_vec_t press,
	input floor_vec_t serve,
	output floor_vec_t calls
);

	// serve is applied after press, so a clear beats a new press
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			calls <= '0;
		end else begin
			calls <= (calls | press) & ~serve & valid_mask;
		end
	end

endmodule

// ==== hdl/elevator_pkg.sv ====
// elevator package: floor count, engine and door encodings, door timing
package elevator_pkg;

	localparam int num_floors = 8;
	localparam int floor_w = 3; // enough for num_floors

	typedef logic [floor_w-1:0] floor_t;
	typedef logic [num_floors-1:0] floor_vec_t; // one bit per floor

	// engine command towards the drive
	typedef enum logic [1:0] {
		engine_idle = 2'd0,
		engine_down = 2'd1,
		engine_up = 2'd2
	} engine_t;

	// door command towards the door operator
	typedef enum logic [1:0] {
		door_idle = 2'd0,
		door_open = 2'd1,
		door_close = 2'd2
	} door_t;

	localparam int dwell_cycles = 4; // open time once sensed fully opened
	localparam int dwell_w = 3; // holds 0 .. dwell_cycles-1

endpackage
